// File: hw/roce_pkg.sv
`default_nettype none

package roce_pkg;

  // address and sequence fields
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [23:0] psn_t;
  typedef logic [23:0] qpn_t;

  // header field widths
  typedef logic [15:0] ethertype_t;
  typedef logic [7:0]  ip_byte_t;
  typedef logic [15:0] ip_word_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [7:0]  bth_opcode_t;
  typedef logic [15:0] pkey_t;

  // eth 14 + ipv4 20 + udp 8 + bth 12 + aeth 4
  localparam int HDR_BYTES    = 58;
  localparam int ETH_HDR_BYTES = 14;
  localparam int IP_HDR_BYTES  = 20;

  // ethernet
  localparam ethertype_t ETH_TYPE_IPV4 = 16'h0800;

  // ipv4, fixed part
  localparam ip_byte_t IP_VER_IHL   = 8'h45;
  localparam ip_byte_t IP_TOS       = 8'hb8;
  localparam ip_word_t IP_ID        = 16'h5555;
  localparam ip_word_t IP_FLAGS     = 16'h4000; // don't fragment
  localparam ip_byte_t IP_TTL       = 8'hba;
  localparam ip_byte_t IP_PROTO_UDP = 8'h11;

  // udp, roce v2 port on the destination side
  localparam udp_port_t UDP_SRC_PORT = 16'h6851;
  localparam udp_port_t UDP_DST_PORT = 16'h12b7;

  // bth
  localparam pkey_t       BTH_PKEY   = 16'h666f;
  localparam bth_opcode_t OP_RD_RESP = 8'h10; // rc read response only
  localparam bth_opcode_t OP_ACK     = 8'h11;

  // peer used for qp 2 and anything out of range
  localparam mac_addr_t  DEF_PEER_MAC = 48'h16c4_5056_0f2e;
  localparam ipv4_addr_t DEF_PEER_IP  = 32'h610c_6007;

endpackage

`default_nettype wire

// File: hw/gen_pkg.sv
`default_nettype none

package gen_pkg;

  localparam int BEAT_BYTES = 64;

  typedef logic [BEAT_BYTES*8-1:0]          beat_t;
  typedef logic [BEAT_BYTES-1:0]            keep_t;
  typedef logic [2:0]                       beat_cnt_t;
  typedef logic [2:0]                       pkt_cnt_t;
  typedef logic [roce_pkg::HDR_BYTES*8-1:0] hdr_t;   // byte 0 in the msb

  typedef enum logic {
    KIND_RD_RESP,
    KIND_ACK
  } pkt_kind_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_POST,
    S_WAIT,
    S_SEND,
    S_DONE
  } seq_state_e;

  typedef struct packed {
    roce_pkg::mac_addr_t  mac;
    roce_pkg::ipv4_addr_t ip;
  } peer_t;

  typedef struct packed {
    pkt_kind_e      kind;
    roce_pkg::qpn_t qpn;
    roce_pkg::psn_t psn;
  } wqe_info_t;

  localparam int RD_RESP_BYTES  = 314;
  localparam int ACK_BYTES      = 58;
  localparam int MAX_BEATS      = (RD_RESP_BYTES + BEAT_BYTES - 1) / BEAT_BYTES;
  localparam int NUM_RD_RESP    = 4;
  localparam int NUM_ACK        = 4;
  localparam int NUM_PEERS      = 5;   // qp 3..7
  localparam int FIRST_PEER_QPN = 3;

  // descriptor byte lanes, msb first
  localparam int PSN_BYTE0 = 51;
  localparam int QPN_BYTE0 = 47;

endpackage

`default_nettype wire

// File: hw/resp_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module resp_sequencer (
  input  wire                 core_clk,
  input  wire                 core_aresetn,
  input  wire                 conf_done_i,
  input  wire                 wqe_valid_i,
  input  wire                 wqe_last_i,
  input  wire                 pkt_done_i,
  output logic                capture_o,
  output gen_pkg::pkt_kind_e  kind_o,
  output logic                post_rd_wqe_o,
  output logic                post_wr_wqe_o,
  output logic                rd_path_done_o,
  output logic                wr_path_done_o
);

  gen_pkg::seq_state_e state;
  gen_pkg::pkt_cnt_t   pkt_cnt;
  logic                phase_end;

  assign capture_o = (state == gen_pkg::S_WAIT);

  // last packet of the current phase
  assign phase_end = (kind_o == gen_pkg::KIND_RD_RESP) ?
                     (pkt_cnt == gen_pkg::pkt_cnt_t'(gen_pkg::NUM_RD_RESP - 1)) :
                     (pkt_cnt == gen_pkg::pkt_cnt_t'(gen_pkg::NUM_ACK - 1));

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state          <= gen_pkg::S_IDLE;
      kind_o         <= gen_pkg::KIND_RD_RESP;
      pkt_cnt        <= '0;
      post_rd_wqe_o  <= 1'b0;
      post_wr_wqe_o  <= 1'b0;
      rd_path_done_o <= 1'b0;
      wr_path_done_o <= 1'b0;
    end else begin
      post_rd_wqe_o <= 1'b0;
      post_wr_wqe_o <= 1'b0;
      case (state)
        gen_pkg::S_IDLE: begin
          if (conf_done_i) begin
            state         <= gen_pkg::S_POST;
            post_rd_wqe_o <= (kind_o == gen_pkg::KIND_RD_RESP);
            post_wr_wqe_o <= (kind_o == gen_pkg::KIND_ACK);
          end
        end
        gen_pkg::S_POST: state <= gen_pkg::S_WAIT; // strobe is high here
        gen_pkg::S_WAIT: begin
          if (wqe_valid_i && wqe_last_i)
            state <= gen_pkg::S_SEND;
        end
        gen_pkg::S_SEND: begin
          if (pkt_done_i) begin
            if (!phase_end) begin
              pkt_cnt       <= pkt_cnt + 1'b1;
              state         <= gen_pkg::S_POST;
              post_rd_wqe_o <= (kind_o == gen_pkg::KIND_RD_RESP);
              post_wr_wqe_o <= (kind_o == gen_pkg::KIND_ACK);
            end else if (kind_o == gen_pkg::KIND_RD_RESP) begin
              // read phase over, straight into the write phase
              rd_path_done_o <= 1'b1;
              kind_o         <= gen_pkg::KIND_ACK;
              pkt_cnt        <= '0;
              state          <= gen_pkg::S_POST;
              post_wr_wqe_o  <= 1'b1;
            end else begin
              wr_path_done_o <= 1'b1;
              state          <= gen_pkg::S_DONE;
            end
          end
        end
        gen_pkg::S_DONE: state <= gen_pkg::S_DONE;
        default:         state <= gen_pkg::S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/wqe_decode.sv
`timescale 1ns/1ns
`default_nettype none

module wqe_decode (
  input  wire                                           core_clk,
  input  wire                                           core_aresetn,
  input  wire gen_pkg::beat_t                           wqe_data_i,
  input  wire                                           wqe_valid_i,
  input  wire                                           wqe_last_i,
  input  wire                                           capture_i,
  input  wire gen_pkg::pkt_kind_e                       kind_i,
  input  wire gen_pkg::peer_t [gen_pkg::NUM_PEERS-1:0]  peers_i,
  output gen_pkg::wqe_info_t                            info_o,
  output gen_pkg::peer_t                                peer_o,
  output logic                                          info_valid_o
);

  logic           first_q;
  logic           take;
  roce_pkg::qpn_t peer_idx;

  assign take = capture_i && wqe_valid_i;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      first_q      <= 1'b1;
      info_valid_o <= 1'b0;
    end else begin
      info_valid_o <= take && wqe_last_i;
      if (take)
        first_q <= wqe_last_i; // rearm after the last beat
    end
  end

  // fields sit in the first descriptor beat only
  always_ff @(posedge core_clk) begin
    if (take && first_q) begin
      info_o.kind <= kind_i;
      info_o.psn  <= {wqe_data_i[gen_pkg::PSN_BYTE0*8 +: 8],
                      wqe_data_i[(gen_pkg::PSN_BYTE0+1)*8 +: 8],
                      wqe_data_i[(gen_pkg::PSN_BYTE0+2)*8 +: 8]};
      info_o.qpn  <= {wqe_data_i[gen_pkg::QPN_BYTE0*8 +: 8],
                      wqe_data_i[(gen_pkg::QPN_BYTE0+1)*8 +: 8],
                      wqe_data_i[(gen_pkg::QPN_BYTE0+2)*8 +: 8]};
    end
  end

  // wraps for qpn below the first peer, so one compare covers both ends
  assign peer_idx = info_o.qpn - roce_pkg::qpn_t'(gen_pkg::FIRST_PEER_QPN);

  always_comb begin
    if (peer_idx < roce_pkg::qpn_t'(gen_pkg::NUM_PEERS)) begin
      peer_o = peers_i[peer_idx[$clog2(gen_pkg::NUM_PEERS)-1:0]];
    end else begin
      peer_o.mac = roce_pkg::DEF_PEER_MAC;
      peer_o.ip  = roce_pkg::DEF_PEER_IP;
    end
  end

endmodule

`default_nettype wire

// File: hw/hdr_build.sv
`timescale 1ns/1ns
`default_nettype none

module hdr_build (
  input  wire                        core_clk,
  input  wire                        core_aresetn,
  input  wire gen_pkg::wqe_info_t    info_i,
  input  wire gen_pkg::peer_t        peer_i,
  input  wire                        info_valid_i,
  input  wire roce_pkg::mac_addr_t   local_mac_i,
  input  wire roce_pkg::ipv4_addr_t  local_ip_i,
  output gen_pkg::hdr_t              hdr_o,
  output gen_pkg::pkt_kind_e         kind_o,
  output logic [7:0]                 psn_lo_o,
  output logic                       hdr_valid_o
);

  roce_pkg::ip_word_t    ip_len;
  roce_pkg::ip_word_t    udp_len;
  roce_pkg::ip_word_t    csum;
  roce_pkg::bth_opcode_t opcode;
  gen_pkg::hdr_t         hdr_d;

  // ones complement over the ten ipv4 words, checksum word taken as zero
  function automatic roce_pkg::ip_word_t ip_csum(input roce_pkg::ip_word_t   tot_len,
                                                 input roce_pkg::ipv4_addr_t src,
                                                 input roce_pkg::ipv4_addr_t dst);
    logic [19:0] sum;
    sum = 20'({roce_pkg::IP_VER_IHL, roce_pkg::IP_TOS}) + 20'(tot_len)
        + 20'(roce_pkg::IP_ID) + 20'(roce_pkg::IP_FLAGS)
        + 20'({roce_pkg::IP_TTL, roce_pkg::IP_PROTO_UDP})
        + 20'(src[31:16]) + 20'(src[15:0])
        + 20'(dst[31:16]) + 20'(dst[15:0]);
    // second fold catches the carry out of the first
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    return ~sum[15:0];
  endfunction

  always_comb begin
    if (info_i.kind == gen_pkg::KIND_RD_RESP) begin
      ip_len = roce_pkg::ip_word_t'(gen_pkg::RD_RESP_BYTES - roce_pkg::ETH_HDR_BYTES);
      opcode = roce_pkg::OP_RD_RESP;
    end else begin
      ip_len = roce_pkg::ip_word_t'(gen_pkg::ACK_BYTES - roce_pkg::ETH_HDR_BYTES);
      opcode = roce_pkg::OP_ACK;
    end
  end

  assign udp_len = ip_len - roce_pkg::ip_word_t'(roce_pkg::IP_HDR_BYTES);
  assign csum    = ip_csum(ip_len, local_ip_i, peer_i.ip);

  assign hdr_d = {
    peer_i.mac, local_mac_i, roce_pkg::ETH_TYPE_IPV4,                     // eth
    roce_pkg::IP_VER_IHL, roce_pkg::IP_TOS, ip_len,
    roce_pkg::IP_ID, roce_pkg::IP_FLAGS,
    roce_pkg::IP_TTL, roce_pkg::IP_PROTO_UDP, csum,
    local_ip_i, peer_i.ip,                                                // ipv4
    roce_pkg::UDP_SRC_PORT, roce_pkg::UDP_DST_PORT, udp_len, 16'h0000,    // udp
    opcode, 8'h00, roce_pkg::BTH_PKEY,
    8'h00, info_i.qpn, 8'h00, info_i.psn,                                 // bth
    32'h0000_0000                                                         // aeth
  };

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn)
      hdr_valid_o <= 1'b0;
    else
      hdr_valid_o <= info_valid_i;
  end

  always_ff @(posedge core_clk) begin
    if (info_valid_i) begin
      hdr_o    <= hdr_d;
      kind_o   <= info_i.kind;
      psn_lo_o <= info_i.psn[7:0]; // payload fill byte
    end
  end

endmodule

`default_nettype wire

// File: hw/beat_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module beat_serializer (
  input  wire                      core_clk,
  input  wire                      core_aresetn,
  input  wire gen_pkg::hdr_t       hdr_i,
  input  wire gen_pkg::pkt_kind_e  kind_i,
  input  wire [7:0]                psn_lo_i,
  input  wire                      hdr_valid_i,
  input  wire                      tx_ready_i,
  output gen_pkg::beat_t           tx_data_o,
  output gen_pkg::keep_t           tx_keep_o,
  output logic                     tx_valid_o,
  output logic                     tx_last_o,
  output logic                     pkt_done_o
);

  localparam int LANES = gen_pkg::MAX_BEATS * gen_pkg::BEAT_BYTES;

  gen_pkg::hdr_t                     hdr_q;
  gen_pkg::pkt_kind_e                kind_q;
  logic [7:0]                        fill_q;
  gen_pkg::beat_cnt_t                beat_q;
  gen_pkg::beat_cnt_t                last_beat;
  logic [9:0]                        pkt_len;
  logic [9:0]                        base;
  logic [LANES*8-1:0]                pkt_lanes;
  logic                              accept;

  assign pkt_len   = (kind_q == gen_pkg::KIND_RD_RESP) ? 10'(gen_pkg::RD_RESP_BYTES) :
                                                          10'(gen_pkg::ACK_BYTES);
  assign last_beat = gen_pkg::beat_cnt_t'((pkt_len - 10'd1) >> 6);
  assign base      = {1'b0, beat_q, 6'd0};

  // whole packet in lane order, wire byte 0 at lane 0
  always_comb begin
    for (int k = 0; k < roce_pkg::HDR_BYTES; k++)
      pkt_lanes[k*8 +: 8] = hdr_q[(roce_pkg::HDR_BYTES-1-k)*8 +: 8];
    for (int k = roce_pkg::HDR_BYTES; k < LANES; k++)
      pkt_lanes[k*8 +: 8] = (k < int'(pkt_len)) ? fill_q : 8'h00;
  end

  assign tx_data_o = pkt_lanes[beat_q*gen_pkg::BEAT_BYTES*8 +: gen_pkg::BEAT_BYTES*8];

  always_comb begin
    for (int j = 0; j < gen_pkg::BEAT_BYTES; j++)
      tx_keep_o[j] = (base + 10'(j)) < pkt_len;
  end

  assign accept     = tx_valid_o && tx_ready_i;
  assign tx_last_o  = tx_valid_o && (beat_q == last_beat);
  assign pkt_done_o = accept && tx_last_o;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      tx_valid_o <= 1'b0;
      beat_q     <= '0;
      kind_q     <= gen_pkg::KIND_RD_RESP;
    end else if (hdr_valid_i) begin
      tx_valid_o <= 1'b1;
      beat_q     <= '0;
      kind_q     <= kind_i;
    end else if (accept) begin
      if (tx_last_o) begin
        tx_valid_o <= 1'b0;
        beat_q     <= '0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (hdr_valid_i) begin
      hdr_q  <= hdr_i;
      fill_q <= psn_lo_i; // ack ignores it
    end
  end

endmodule

`default_nettype wire

// File: hw/rdma_resp_gen.sv
`timescale 1ns/1ns
`default_nettype none

module rdma_resp_gen (
  input  wire                                           core_clk,
  input  wire                                           core_aresetn,
  input  wire                                           conf_done_i,
  input  wire gen_pkg::beat_t                           wqe_data_i,
  input  wire                                           wqe_valid_i,
  input  wire                                           wqe_last_i,
  input  wire                                           tx_ready_i,
  input  wire roce_pkg::mac_addr_t                      local_mac_i,
  input  wire roce_pkg::ipv4_addr_t                     local_ip_i,
  input  wire gen_pkg::peer_t [gen_pkg::NUM_PEERS-1:0]  peers_i,
  output gen_pkg::beat_t                                tx_data_o,
  output gen_pkg::keep_t                                tx_keep_o,
  output logic                                          tx_valid_o,
  output logic                                          tx_last_o,
  output logic                                          post_rd_wqe_o,
  output logic                                          post_wr_wqe_o,
  output logic                                          rd_path_done_o,
  output logic                                          wr_path_done_o
);

  logic               capture;
  gen_pkg::pkt_kind_e seq_kind;
  gen_pkg::wqe_info_t info;
  gen_pkg::peer_t     peer;
  logic               info_valid;
  gen_pkg::hdr_t      hdr;
  gen_pkg::pkt_kind_e hdr_kind;
  logic [7:0]         psn_lo;
  logic               hdr_valid;
  logic               pkt_done;

  resp_sequencer u_seq (
    .core_clk, .core_aresetn, .conf_done_i, .wqe_valid_i, .wqe_last_i,
    .pkt_done_i(pkt_done), .capture_o(capture), .kind_o(seq_kind),
    .post_rd_wqe_o, .post_wr_wqe_o, .rd_path_done_o, .wr_path_done_o
  );

  wqe_decode u_decode (
    .core_clk, .core_aresetn, .wqe_data_i, .wqe_valid_i, .wqe_last_i,
    .capture_i(capture), .kind_i(seq_kind), .peers_i,
    .info_o(info), .peer_o(peer), .info_valid_o(info_valid)
  );

  hdr_build u_hdr (
    .core_clk, .core_aresetn, .info_i(info), .peer_i(peer), .info_valid_i(info_valid),
    .local_mac_i, .local_ip_i,
    .hdr_o(hdr), .kind_o(hdr_kind), .psn_lo_o(psn_lo), .hdr_valid_o(hdr_valid)
  );

  beat_serializer u_ser (
    .core_clk, .core_aresetn, .hdr_i(hdr), .kind_i(hdr_kind), .psn_lo_i(psn_lo),
    .hdr_valid_i(hdr_valid), .tx_ready_i,
    .tx_data_o, .tx_keep_o, .tx_valid_o, .tx_last_o, .pkt_done_o(pkt_done)
  );

endmodule

`default_nettype wire

// File: test/tb_rdma_resp_gen_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rdma_resp_gen_assertions (
  input wire                 core_clk,
  input wire                 core_aresetn,
  input wire gen_pkg::beat_t tx_data_o,
  input wire gen_pkg::keep_t tx_keep_o,
  input wire                 tx_valid_o,
  input wire                 tx_last_o,
  input wire                 tx_ready_i,
  input wire                 post_rd_wqe_o,
  input wire                 post_wr_wqe_o,
  input wire                 rd_path_done_o,
  input wire                 wr_path_done_o
);

  int fail_cnt = 0;

  // stalled beat holds
  a_hold: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o) &&
    $stable(tx_keep_o) && $stable(tx_last_o))
    else begin
      fail_cnt++;
      $error("beat changed under back-pressure");
    end

  a_rd_pulse: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    post_rd_wqe_o |=> !post_rd_wqe_o)
    else begin
      fail_cnt++;
      $error("read post longer than one cycle");
    end

  a_wr_pulse: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    post_wr_wqe_o |=> !post_wr_wqe_o)
    else begin
      fail_cnt++;
      $error("write post longer than one cycle");
    end

  a_rd_sticky: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    rd_path_done_o |=> rd_path_done_o)
    else begin
      fail_cnt++;
      $error("rd_path_done_o fell");
    end

  a_wr_sticky: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    wr_path_done_o |=> wr_path_done_o)
    else begin
      fail_cnt++;
      $error("wr_path_done_o fell");
    end

endmodule

bind rdma_resp_gen tb_rdma_resp_gen_assertions i_assertions (.*);

`default_nettype wire

// File: test/tb_rdma_resp_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rdma_resp_gen;

  localparam int TOTAL_PKTS  = gen_pkg::NUM_RD_RESP + gen_pkg::NUM_ACK;
  localparam int WATCHDOG_NS = (TOTAL_PKTS * 400 + 10) * 10;

  logic                                    core_clk;
  logic                                    core_aresetn;
  logic                                    conf_done_i;
  gen_pkg::beat_t                          wqe_data_i;
  logic                                    wqe_valid_i;
  logic                                    wqe_last_i;
  logic                                    tx_ready_i;
  roce_pkg::mac_addr_t                     local_mac_i;
  roce_pkg::ipv4_addr_t                    local_ip_i;
  gen_pkg::peer_t [gen_pkg::NUM_PEERS-1:0] peers_i;
  gen_pkg::beat_t                          tx_data_o;
  gen_pkg::keep_t                          tx_keep_o;
  logic                                    tx_valid_o;
  logic                                    tx_last_o;
  logic                                    post_rd_wqe_o;
  logic                                    post_wr_wqe_o;
  logic                                    rd_path_done_o;
  logic                                    wr_path_done_o;

  logic [31:0]        stim_seed = 32'h1b47;
  logic [31:0]        rdy_seed  = 32'h1b47;
  gen_pkg::wqe_info_t exp_q[$];
  int                 rd_cnt    = 0;
  int                 ack_cnt   = 0;

  rdma_resp_gen i_dut (.*);

  always #5 core_clk = ~core_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_seed = lcg_next(stim_seed);
    return stim_seed;
  endfunction

  function automatic int pkt_bytes(input gen_pkg::pkt_kind_e kind);
    return (kind == gen_pkg::KIND_RD_RESP) ? 314 : 58;
  endfunction

  // ipv4 header words added up before folding, checksum word zero
  function automatic logic [31:0] ip_word_sum(input logic [15:0] tot_len,
                                             input logic [31:0] src,
                                             input logic [31:0] dst);
    return 32'h4500 + 32'h00b8 + tot_len + 32'h5555 + 32'h4000 + 32'hba11
         + src[31:16] + src[15:0] + dst[31:16] + dst[15:0];
  endfunction

  // expected wire bytes, byte k at bits k*8
  function automatic logic [2559:0] ref_packet(input gen_pkg::wqe_info_t info);
    logic [2559:0]        pkt;
    logic [463:0]         hdr;
    logic [31:0]          sum;
    logic [15:0]          tot_len;
    logic [15:0]          csum;
    roce_pkg::mac_addr_t  pmac;
    roce_pkg::ipv4_addr_t pip;
    int                   len;
    len     = pkt_bytes(info.kind);
    tot_len = 16'(len - 14);
    if (info.qpn >= 3 && info.qpn <= 7) begin
      pmac = peers_i[info.qpn - 3].mac;
      pip  = peers_i[info.qpn - 3].ip;
    end else begin
      pmac = 48'h16c4_5056_0f2e;
      pip  = 32'h610c_6007;
    end
    sum = ip_word_sum(tot_len, local_ip_i, pip);
    while (sum[31:16] != 0)
      sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    csum = ~sum[15:0];
    hdr = {pmac, local_mac_i, 16'h0800,
           8'h45, 8'hb8, tot_len, 16'h5555, 16'h4000, 8'hba, 8'h11, csum,
           local_ip_i, pip,
           16'h6851, 16'h12b7, tot_len - 16'd20, 16'h0000,
           (info.kind == gen_pkg::KIND_RD_RESP) ? 8'h10 : 8'h11, 8'h00, 16'h666f,
           8'h00, info.qpn, 8'h00, info.psn,
           32'h0};
    pkt = '0;
    for (int k = 0; k < len; k++)
      pkt[k*8 +: 8] = (k < 58) ? hdr[(57-k)*8 +: 8] : info.psn[7:0];
    return pkt;
  endfunction

  task automatic report_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_beat(input gen_pkg::beat_t got, input gen_pkg::beat_t exp,
                            input string what);
    if (got !== exp)
      report_failure($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_keep(input gen_pkg::keep_t got, input gen_pkg::keep_t exp);
    if (got !== exp)
      report_failure($sformatf("keep got %h expected %h", got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_failure($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  // random back-pressure, about one cycle in four
  always @(posedge core_clk) begin
    #1;
    rdy_seed   = lcg_next(rdy_seed);
    tx_ready_i = (rdy_seed[17:16] != 2'b00);
  end

  // answers each post strobe with a descriptor
  initial begin : wqe_driver
    gen_pkg::wqe_info_t info;
    int                 nbeats;
    forever begin
      @(posedge core_clk);
      #1;
      if (post_rd_wqe_o || post_wr_wqe_o) begin
        check_flag(wr_path_done_o, 1'b0, "post after write phase done");
        if (post_rd_wqe_o) begin
          check_flag(rd_path_done_o, 1'b0, "rd_path_done_o at read post");
          info.kind = gen_pkg::KIND_RD_RESP;
        end else begin
          check_flag(rd_path_done_o, 1'b1, "rd_path_done_o at write post");
          check_flag(rd_cnt == gen_pkg::NUM_RD_RESP, 1'b1, "all reads before write post");
          info.kind = gen_pkg::KIND_ACK;
        end
        info.psn = 24'(stim_rand());
        info.qpn = 24'(2 + stim_rand() % 7);
        exp_q.push_back(info);
        nbeats = 1 + stim_rand() % 3;
        @(posedge core_clk); // sequencer moves into its wait state
        #1;
        for (int b = 0; b < nbeats; b++) begin
          for (int w = 0; w < 16; w++)
            wqe_data_i[w*32 +: 32] = stim_rand();
          if (b == 0) begin
            for (int i = 0; i < 3; i++) begin
              wqe_data_i[(gen_pkg::PSN_BYTE0+i)*8 +: 8] = info.psn[(2-i)*8 +: 8];
              wqe_data_i[(gen_pkg::QPN_BYTE0+i)*8 +: 8] = info.qpn[(2-i)*8 +: 8];
            end
          end
          wqe_valid_i = 1'b1;
          wqe_last_i  = (b == nbeats - 1);
          @(posedge core_clk);
          #1;
        end
        wqe_valid_i = 1'b0;
        wqe_last_i  = 1'b0;
      end
    end
  end

  // compare process, outputs are settled at the falling edge
  initial begin : compare
    gen_pkg::wqe_info_t cur;
    logic [2559:0]      pkt;
    gen_pkg::keep_t     keep;
    gen_pkg::beat_t     mask;
    int                 idx;
    logic               last;
    idx = 0;
    forever begin
      @(negedge core_clk);
      if (core_aresetn && tx_valid_o && tx_ready_i) begin
        if (idx == 0) begin
          if (exp_q.size() == 0)
            report_failure("beat sent without a posted descriptor");
          cur = exp_q.pop_front();
          pkt = ref_packet(cur);
        end
        for (int j = 0; j < 64; j++) begin
          keep[j]         = (idx * 64 + j) < pkt_bytes(cur.kind);
          mask[j*8 +: 8]  = {8{keep[j]}};
        end
        last = ((idx + 1) * 64 >= pkt_bytes(cur.kind));
        check_beat(tx_data_o & mask, pkt[idx*512 +: 512] & mask, "data");
        check_keep(tx_keep_o, keep);
        check_flag(tx_last_o, last, "last");
        if (last) begin
          idx = 0;
          if (cur.kind == gen_pkg::KIND_RD_RESP)
            rd_cnt++;
          else
            ack_cnt++;
        end else begin
          idx++;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the packet sequence did not finish in time");
    $display("Checks failed");
    $fatal(1);
  end

  initial begin
    core_clk     = 1'b0;
    core_aresetn = 1'b0;
    conf_done_i  = 1'b0;
    wqe_data_i   = '0;
    wqe_valid_i  = 1'b0;
    wqe_last_i   = 1'b0;
    tx_ready_i   = 1'b0;
    local_mac_i  = {stim_rand(), stim_rand()} >> 16;
    // low address halves picked so every read response sum needs a second fold
    local_ip_i   = stim_rand() & 32'hffff_0000;
    local_ip_i[15:0] = 16'hffff - 16'(ip_word_sum(16'd300, local_ip_i, 32'h610c_6007));
    for (int p = 0; p < gen_pkg::NUM_PEERS; p++) begin
      peers_i[p].mac = {stim_rand(), stim_rand()} >> 16;
      peers_i[p].ip  = stim_rand() & 32'hffff_0000;
      peers_i[p].ip[15:0] = 16'hffff - 16'(ip_word_sum(16'd300, local_ip_i, peers_i[p].ip));
    end
    repeat (3) @(posedge core_clk);
    #1;
    core_aresetn = 1'b1;
    check_flag(tx_valid_o | tx_last_o | post_rd_wqe_o | post_wr_wqe_o | rd_path_done_o |
               wr_path_done_o, 1'b0, "outputs after reset");
    repeat (2) @(posedge core_clk);
    #1;
    conf_done_i = 1'b1;
    wait (wr_path_done_o);
    check_flag(ack_cnt == gen_pkg::NUM_ACK, 1'b1, "all acks before wr_path_done_o");
    repeat (20) @(posedge core_clk); // no further posts or beats
    check_flag(rd_cnt == gen_pkg::NUM_RD_RESP && ack_cnt == gen_pkg::NUM_ACK, 1'b1,
               "packet counts at end");
    check_flag(exp_q.size() == 0, 1'b1, "descriptors left without a packet");
    if (i_dut.i_assertions.fail_cnt == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: rdma_resp_gen.f
hw/roce_pkg.sv
hw/gen_pkg.sv
hw/resp_sequencer.sv
hw/wqe_decode.sv
hw/hdr_build.sv
hw/beat_serializer.sv
hw/rdma_resp_gen.sv
test/tb_rdma_resp_gen_assertions.sv
test/tb_rdma_resp_gen.sv

// File: Makefile
# Verilator build and run of the response generator testbench

SRCS := $(wildcard hw/*.sv test/*.sv) rdma_resp_gen.f

.PHONY: all run clean

all: run

obj_dir/Vtb_rdma_resp_gen: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_rdma_resp_gen -f rdma_resp_gen.f \
		-Mdir obj_dir -o Vtb_rdma_resp_gen

sim.log: obj_dir/Vtb_rdma_resp_gen
	-./obj_dir/Vtb_rdma_resp_gen > sim.log 2>&1

run: obj_dir/Vtb_rdma_resp_gen
	-./obj_dir/Vtb_rdma_resp_gen > sim.log 2>&1
	@cat sim.log
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
